// File: src/ray_pkg.sv
package ray_pkg;

  // signed Q16.16
  localparam int NUM_FRAC_DIGITS = 16;
  typedef logic signed [31:0] fp;

  localparam fp FP_ZERO = '0;
  localparam fp FP_ONE = fp'(1 << NUM_FRAC_DIGITS);
  localparam fp FP_THREE_HALVES = fp'(3 << (NUM_FRAC_DIGITS - 1));

  localparam int DISPLAY_WIDTH = 32;
  localparam int DISPLAY_HEIGHT = 24;
  localparam int H_BITS = 6;
  localparam int V_BITS = 5;

  typedef logic [H_BITS-1:0] hcount_t;
  typedef logic [V_BITS-1:0] vcount_t;

  localparam fp FP_DISPLAY_WIDTH = fp'(DISPLAY_WIDTH << NUM_FRAC_DIGITS);
  localparam fp FP_DISPLAY_HEIGHT = fp'(DISPLAY_HEIGHT << NUM_FRAC_DIGITS);
  // rounded to nearest lsb
  localparam fp FP_INV_DISPLAY_HEIGHT =
    fp'((2 * (1 << NUM_FRAC_DIGITS) + DISPLAY_HEIGHT) / (2 * DISPLAY_HEIGHT));

  // inverse sqrt seed mantissas, 0.825 and 0.825/sqrt(2)
  localparam fp ISQRT_SEED_EVEN = fp'(54067);
  localparam fp ISQRT_SEED_ODD = fp'(38231);
  localparam int NEWTON_STEPS = 3;

  typedef struct packed {
    fp x;
    fp y;
    fp z;
  } vec3;

  typedef struct packed {
    vec3     origin;
    vec3     direction;
    hcount_t hcount;
    vcount_t vcount;
  } ray_t;

  typedef struct packed {
    vec3 pos;
    vec3 forward;
  } cam_t;

  typedef logic [2:0] cam_addr_t;

  localparam cam_addr_t CAM_ADDR_POS_X = 3'd0;
  localparam cam_addr_t CAM_ADDR_POS_Y = 3'd1;
  localparam cam_addr_t CAM_ADDR_POS_Z = 3'd2;
  localparam cam_addr_t CAM_ADDR_FWD_X = 3'd3;
  localparam cam_addr_t CAM_ADDR_FWD_Y = 3'd4;
  localparam cam_addr_t CAM_ADDR_FWD_Z = 3'd5;

  // camera at the origin looking down +z
  localparam cam_t CAM_DEFAULT = '{
    pos: '{x: FP_ZERO, y: FP_ZERO, z: FP_ZERO},
    forward: '{x: FP_ZERO, y: FP_ZERO, z: FP_ONE}
  };

  function automatic fp fp_mul(input fp a, input fp b);
    logic signed [63:0] prod;
    prod = 64'(a) * 64'(b);
    return fp'(prod >>> NUM_FRAC_DIGITS);
  endfunction

  function automatic fp fp_sub(input fp a, input fp b);
    return a - b;
  endfunction

  function automatic vec3 make_vec3(input fp x, input fp y, input fp z);
    vec3 v;
    v.x = x;
    v.y = y;
    v.z = z;
    return v;
  endfunction

  function automatic vec3 vec3_add(input vec3 a, input vec3 b);
    return make_vec3(a.x + b.x, a.y + b.y, a.z + b.z);
  endfunction

  function automatic vec3 vec3_scaled(input vec3 a, input fp s);
    return make_vec3(fp_mul(a.x, s), fp_mul(a.y, s), fp_mul(a.z, s));
  endfunction

  function automatic fp vec3_dot(input vec3 a, input vec3 b);
    return fp_mul(a.x, b.x) + fp_mul(a.y, b.y) + fp_mul(a.z, b.z);
  endfunction

  function automatic vec3 vec3_cross(input vec3 a, input vec3 b);
    return make_vec3(fp_sub(fp_mul(a.y, b.z), fp_mul(a.z, b.y)),
                     fp_sub(fp_mul(a.z, b.x), fp_mul(a.x, b.z)),
                     fp_sub(fp_mul(a.x, b.y), fp_mul(a.y, b.x)));
  endfunction

endpackage

// File: src/camera_regs.sv
`timescale 1ns/10ps
`default_nettype none

module camera_regs (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                wr_en,
  input  ray_pkg::cam_addr_t  wr_addr,
  input  ray_pkg::fp          wr_data,
  input  logic                frame_start,
  output ray_pkg::cam_t       cam
);

  // values written by software, not yet visible to the scanner
  ray_pkg::cam_t shadow;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      shadow <= ray_pkg::CAM_DEFAULT;
      cam <= ray_pkg::CAM_DEFAULT;
    end else begin
      if (wr_en) begin
        case (wr_addr)
          ray_pkg::CAM_ADDR_POS_X: begin
            shadow.pos.x <= wr_data;
          end
          ray_pkg::CAM_ADDR_POS_Y: begin
            shadow.pos.y <= wr_data;
          end
          ray_pkg::CAM_ADDR_POS_Z: begin
            shadow.pos.z <= wr_data;
          end
          ray_pkg::CAM_ADDR_FWD_X: begin
            shadow.forward.x <= wr_data;
          end
          ray_pkg::CAM_ADDR_FWD_Y: begin
            shadow.forward.y <= wr_data;
          end
          ray_pkg::CAM_ADDR_FWD_Z: begin
            shadow.forward.z <= wr_data;
          end
          // addresses 6 and 7 are unmapped
          default: ;
        endcase
      end

      // a write on the frame_start cycle lands in the next frame
      if (frame_start) begin
        cam <= shadow;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/pixel_scanner.sv
`timescale 1ns/10ps
`default_nettype none

module pixel_scanner (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              start,
  input  logic              gen_ready,
  input  logic              gen_done,
  output logic              pix_valid,
  output ray_pkg::hcount_t  hcount,
  output ray_pkg::vcount_t  vcount,
  output logic              frame_start,
  output logic              frame_busy,
  output logic              frame_done
);

  typedef enum logic [1:0] {
    SC_IDLE,
    SC_ISSUE,
    SC_WAIT_RAY,
    SC_FINISH
  } scan_state_t;

  scan_state_t state;
  logic last_h;
  logic last_v;

  assign last_h = (hcount == ray_pkg::hcount_t'(ray_pkg::DISPLAY_WIDTH - 1));
  assign last_v = (vcount == ray_pkg::vcount_t'(ray_pkg::DISPLAY_HEIGHT - 1));

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= SC_IDLE;
      pix_valid <= 1'b0;
      hcount <= '0;
      vcount <= '0;
      frame_start <= 1'b0;
      frame_busy <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      pix_valid <= 1'b0;
      frame_start <= 1'b0;
      frame_done <= 1'b0;
      case (state)
        SC_IDLE: begin
          // start is only looked at here
          if (start) begin
            frame_start <= 1'b1;
            frame_busy <= 1'b1;
            hcount <= '0;
            vcount <= '0;
            state <= SC_ISSUE;
          end
        end
        SC_ISSUE: begin
          if (gen_ready) begin
            pix_valid <= 1'b1;
            state <= SC_WAIT_RAY;
          end
        end
        SC_WAIT_RAY: begin
          if (gen_done) begin
            if (last_h && last_v) begin
              frame_done <= 1'b1;
              state <= SC_FINISH;
            end else begin
              // raster order, hcount fastest
              if (last_h) begin
                hcount <= '0;
                vcount <= vcount + 1'b1;
              end else begin
                hcount <= hcount + 1'b1;
              end
              // generator raises ready together with its ray
              if (gen_ready) begin
                pix_valid <= 1'b1;
              end else begin
                state <= SC_ISSUE;
              end
            end
          end
        end
        SC_FINISH: begin
          frame_busy <= 1'b0;
          state <= SC_IDLE;
        end
        default: state <= SC_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/fp_inv_sqrt_folded.sv
`timescale 1ns/10ps
`default_nettype none

module fp_inv_sqrt_folded (
  input  logic        clk_in,
  input  logic        rst_in,
  input  ray_pkg::fp  a_in,
  input  logic        valid_in,
  output ray_pkg::fp  res_out,
  output logic        valid_out,
  output logic        ready_out
);

  // three phases per newton step, one multiply each
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SQUARE,
    ST_SCALE,
    ST_UPDATE
  } isqrt_state_t;

  isqrt_state_t state;
  logic [1:0] step;
  ray_pkg::fp a_reg;
  ray_pkg::fp y;
  ray_pkg::fp half_ayy;

  logic [4:0] lead_pos;
  ray_pkg::fp seed_base;
  ray_pkg::fp seed;
  ray_pkg::fp mul_a;
  ray_pkg::fp mul_b;
  ray_pkg::fp prod;

  // leading one of a_in gives its binary exponent, offset by 16
  always_comb begin
    lead_pos = '0;
    for (int i = 0; i < 31; i++) begin
      if (a_in[i]) begin
        lead_pos = 5'(i);
      end
    end
  end

  // odd exponent needs the extra 1/sqrt(2)
  assign seed_base = lead_pos[0] ? ray_pkg::ISQRT_SEED_ODD : ray_pkg::ISQRT_SEED_EVEN;
  assign seed = (seed_base << 8) >> lead_pos[4:1];

  // shared multiplier operand select
  always_comb begin
    case (state)
      ST_SCALE: begin
        mul_a = a_reg;
        mul_b = half_ayy;
      end
      ST_UPDATE: begin
        mul_a = y;
        mul_b = ray_pkg::fp_sub(ray_pkg::FP_THREE_HALVES, half_ayy);
      end
      default: begin
        mul_a = y;
        mul_b = y;
      end
    endcase
  end

  assign prod = ray_pkg::fp_mul(mul_a, mul_b);
  assign ready_out = (state == ST_IDLE);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= ST_IDLE;
      step <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (valid_in) begin
            a_reg <= a_in;
            y <= seed;
            step <= '0;
            state <= ST_SQUARE;
          end
        end
        ST_SQUARE: begin
          half_ayy <= prod;
          state <= ST_SCALE;
        end
        ST_SCALE: begin
          half_ayy <= prod >>> 1;
          state <= ST_UPDATE;
        end
        ST_UPDATE: begin
          y <= prod;
          if (step == 2'(ray_pkg::NEWTON_STEPS - 1)) begin
            // last step writes the output register directly
            res_out <= prod;
            valid_out <= 1'b1;
            state <= ST_IDLE;
          end else begin
            step <= step + 1'b1;
            state <= ST_SQUARE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/ray_generator_folded.sv
`timescale 1ns/10ps
`default_nettype none

module ray_generator_folded (
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              valid_in,
  input  ray_pkg::hcount_t  hcount_in,
  input  ray_pkg::vcount_t  vcount_in,
  input  ray_pkg::cam_t     cam_in,
  output logic              valid_out,
  output logic              ready_out,
  output ray_pkg::ray_t     ray_out
);

  typedef enum logic [2:0] {
    ST_INPUT,
    ST_RIGHT,
    ST_UP,
    ST_SCREEN,
    ST_SCALE,
    ST_NORM,
    ST_WAIT_NORM
  } gen_state_t;

  gen_state_t state;

  // captured at accept
  ray_pkg::hcount_t hcount;
  ray_pkg::vcount_t vcount;
  ray_pkg::cam_t cam;

  ray_pkg::vec3 cam_right;
  ray_pkg::vec3 cam_up;
  ray_pkg::fp px;
  ray_pkg::fp py;
  ray_pkg::vec3 scaled_right;
  ray_pkg::vec3 scaled_up;
  ray_pkg::vec3 ray_dir;

  ray_pkg::fp h2_fp;
  ray_pkg::fp v2_fp;
  ray_pkg::vec3 dir_sum;
  ray_pkg::fp len_sq;

  logic isqrt_valid_in;
  logic isqrt_valid_out;
  logic isqrt_ready;
  ray_pkg::fp isqrt_res;

  // 2h and 2v in fixed point
  assign h2_fp = ray_pkg::fp'(hcount) <<< (ray_pkg::NUM_FRAC_DIGITS + 1);
  assign v2_fp = ray_pkg::fp'(vcount) <<< (ray_pkg::NUM_FRAC_DIGITS + 1);

  assign dir_sum = ray_pkg::vec3_add(ray_pkg::vec3_add(scaled_right, scaled_up),
                                     cam.forward);
  assign len_sq = ray_pkg::vec3_dot(ray_dir, ray_dir);

  fp_inv_sqrt_folded isqrt (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .a_in      (len_sq),
    .valid_in  (isqrt_valid_in),
    .res_out   (isqrt_res),
    .valid_out (isqrt_valid_out),
    .ready_out (isqrt_ready)
  );

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= ST_INPUT;
      valid_out <= 1'b0;
      ready_out <= 1'b1;
      isqrt_valid_in <= 1'b0;
    end else begin
      valid_out <= 1'b0;
      isqrt_valid_in <= 1'b0;
      case (state)
        ST_INPUT: begin
          if (valid_in) begin
            hcount <= hcount_in;
            vcount <= vcount_in;
            cam <= cam_in;
            ready_out <= 1'b0;
            state <= ST_RIGHT;
          end
        end
        ST_RIGHT: begin
          // world up crossed with forward
          cam_right <= ray_pkg::vec3_cross(
            ray_pkg::make_vec3(ray_pkg::FP_ZERO, ray_pkg::FP_ONE, ray_pkg::FP_ZERO),
            cam.forward);
          state <= ST_UP;
        end
        ST_UP: begin
          cam_up <= ray_pkg::vec3_cross(cam.forward, cam_right);
          state <= ST_SCREEN;
        end
        ST_SCREEN: begin
          // both axes divided by height to keep pixels square
          px <= ray_pkg::fp_mul(ray_pkg::fp_sub(h2_fp, ray_pkg::FP_DISPLAY_WIDTH),
                                ray_pkg::FP_INV_DISPLAY_HEIGHT);
          py <= ray_pkg::fp_mul(ray_pkg::fp_sub(v2_fp, ray_pkg::FP_DISPLAY_HEIGHT),
                                ray_pkg::FP_INV_DISPLAY_HEIGHT);
          state <= ST_SCALE;
        end
        ST_SCALE: begin
          scaled_right <= ray_pkg::vec3_scaled(cam_right, px);
          scaled_up <= ray_pkg::vec3_scaled(cam_up, py);
          state <= ST_NORM;
        end
        ST_NORM: begin
          if (isqrt_ready) begin
            ray_dir <= dir_sum;
            isqrt_valid_in <= 1'b1;
            state <= ST_WAIT_NORM;
          end
        end
        ST_WAIT_NORM: begin
          if (isqrt_valid_out) begin
            ray_out.origin <= cam.pos;
            ray_out.direction <= ray_pkg::vec3_scaled(ray_dir, isqrt_res);
            ray_out.hcount <= hcount;
            ray_out.vcount <= vcount;
            valid_out <= 1'b1;
            ready_out <= 1'b1;
            state <= ST_INPUT;
          end
        end
        default: state <= ST_INPUT;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/ray_caster_top.sv
`timescale 1ns/10ps
`default_nettype none

module ray_caster_top (
  input  logic                clk_in,
  input  logic                rst_in,
  input  logic                wr_en,
  input  ray_pkg::cam_addr_t  wr_addr,
  input  ray_pkg::fp          wr_data,
  input  logic                start,
  output logic                frame_busy,
  output logic                frame_done,
  output ray_pkg::ray_t       ray,
  output logic                ray_valid
);

  ray_pkg::cam_t cam;
  logic frame_start;
  logic pix_valid;
  logic gen_ready;
  ray_pkg::hcount_t hcount;
  ray_pkg::vcount_t vcount;

  camera_regs cam_regs (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .frame_start (frame_start),
    .cam         (cam)
  );

  // ray_valid doubles as the scanner's done strobe
  pixel_scanner scanner (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .start       (start),
    .gen_ready   (gen_ready),
    .gen_done    (ray_valid),
    .pix_valid   (pix_valid),
    .hcount      (hcount),
    .vcount      (vcount),
    .frame_start (frame_start),
    .frame_busy  (frame_busy),
    .frame_done  (frame_done)
  );

  ray_generator_folded generator (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .valid_in  (pix_valid),
    .hcount_in (hcount),
    .vcount_in (vcount),
    .cam_in    (cam),
    .valid_out (ray_valid),
    .ready_out (gen_ready),
    .ray_out   (ray)
  );

endmodule

`default_nettype wire

// File: test/ray_caster_asserts.sv
`timescale 1ns/10ps

module ray_caster_asserts (
  input logic clk_in,
  input logic rst_in,
  input logic req,
  input logic ready,
  input logic pulse
);

  // set once the first request has been taken
  logic seen_req;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      seen_req <= 1'b0;
    end else if (req && ready) begin
      seen_req <= 1'b1;
    end
  end

  req_only_when_ready: assert property (
    @(posedge clk_in) disable iff (rst_in) req |-> ready
  ) else $error("request raised while ready is low");

  pulse_single_cycle: assert property (
    @(posedge clk_in) disable iff (rst_in) pulse |=> !pulse
  ) else $error("output pulse lasted more than one cycle");

  pulse_after_request: assert property (
    @(posedge clk_in) disable iff (rst_in) pulse |-> seen_req
  ) else $error("output pulse before any request was accepted");

endmodule

// pixel handshake into the generator and its ray_valid
bind ray_generator_folded ray_caster_asserts gen_checks (
  .clk_in (clk_in),
  .rst_in (rst_in),
  .req    (valid_in),
  .ready  (ready_out),
  .pulse  (valid_out)
);

// scanner side of the same handshake, plus frame_done
bind pixel_scanner ray_caster_asserts scan_checks (
  .clk_in (clk_in),
  .rst_in (rst_in),
  .req    (pix_valid),
  .ready  (gen_ready),
  .pulse  (frame_done)
);

// File: test/ray_caster_tb.sv
`timescale 1ns/10ps

module ray_caster_tb;

  localparam int NUM_PIXELS = ray_pkg::DISPLAY_WIDTH * ray_pkg::DISPLAY_HEIGHT;
  // generator bound of 32 cycles per pixel plus scanner overhead
  localparam int FRAME_CYCLE_LIMIT = NUM_PIXELS * 32 + 100;
  // six frames at under 20 cycles per pixel, plus writes and idle gaps
  localparam int TIMEOUT_CYCLES = 6 * NUM_PIXELS * 20 + 8000;
  localparam real DIR_TOL = 1.0 / 256.0;
  localparam real LEN_TOL = 1.0 / 128.0;

  logic clk_in;
  logic rst_in;
  logic wr_en;
  ray_pkg::cam_addr_t wr_addr;
  ray_pkg::fp wr_data;
  logic start;
  logic frame_busy;
  logic frame_done;
  ray_pkg::ray_t ray;
  logic ray_valid;

  ray_pkg::ray_t ray_q[$];
  int done_count = 0;
  int done_base = 0;
  int rays_at_done = 0;
  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int failed_tests = 0;
  int test_start_errors = 0;
  int cycle_count = 0;
  integer seed;

  ray_pkg::vec3 cam_a_pos;
  ray_pkg::vec3 cam_a_fwd;
  ray_pkg::vec3 cam_b_pos;
  ray_pkg::vec3 cam_b_fwd;
  ray_pkg::vec3 rand_fwd;

  ray_caster_top UUT (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .start      (start),
    .frame_busy (frame_busy),
    .frame_done (frame_done),
    .ray        (ray),
    .ray_valid  (ray_valid)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_in);
      cycle_count++;
    end
    $display("timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  // collects rays and remembers how many had arrived at each frame_done
  always @(posedge clk_in) begin
    if (!rst_in && ray_valid) begin
      ray_q.push_back(ray);
    end
    if (!rst_in && frame_done) begin
      done_count++;
      rays_at_done = ray_q.size();
    end
  end

  function automatic real fp_to_real(input ray_pkg::fp v);
    return $itor(v) / 65536.0;
  endfunction

  function automatic ray_pkg::fp real_to_fp(input real r);
    return ray_pkg::fp'($rtoi(r * 65536.0));
  endfunction

  function automatic ray_pkg::vec3 vec_of(input real x, input real y, input real z);
    ray_pkg::vec3 v;
    v.x = real_to_fp(x);
    v.y = real_to_fp(y);
    v.z = real_to_fp(z);
    return v;
  endfunction

  // expected unit direction component selected by axis (0 x, 1 y, 2 z)
  function automatic real ref_component(input real fx, input real fy, input real fz,
                                        input int h, input int v, input int axis);
    real rx, rz, ux, uy, uz;
    real px, py, sx, sy, sz, len;
    // right = (0,1,0) x forward, up = forward x right
    rx = fz;
    rz = -fx;
    ux = fy * rz;
    uy = fz * rx - fx * rz;
    uz = -fy * rx;
    px = (2.0 * h - ray_pkg::DISPLAY_WIDTH) / ray_pkg::DISPLAY_HEIGHT;
    py = (2.0 * v - ray_pkg::DISPLAY_HEIGHT) / ray_pkg::DISPLAY_HEIGHT;
    sx = rx * px + ux * py + fx;
    sy = uy * py + fy;
    sz = rz * px + uz * py + fz;
    len = $sqrt(sx * sx + sy * sy + sz * sz);
    if (axis == 0) begin
      return sx / len;
    end else if (axis == 1) begin
      return sy / len;
    end
    return sz / len;
  endfunction

  task automatic check_value(input string name, input real got, input real expected,
                             input real tol);
    check_count++;
    if ((got - expected > tol) || (expected - got > tol)) begin
      error_count++;
      $display("mismatch at %0t ns: %s got %0.6f expected %0.6f",
               $time, name, got, expected);
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    if (error_count != test_start_errors) begin
      failed_tests++;
      $display("test %s: %0d errors", name, error_count - test_start_errors);
    end else begin
      $display("test %s: ok", name);
    end
    test_start_errors = error_count;
  endtask

  task automatic write_reg(input ray_pkg::cam_addr_t addr, input ray_pkg::fp data);
    @(posedge clk_in);
    #1;
    wr_en = 1'b1;
    wr_addr = addr;
    wr_data = data;
    @(posedge clk_in);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic write_forward(input ray_pkg::vec3 fwd);
    write_reg(ray_pkg::CAM_ADDR_FWD_X, fwd.x);
    write_reg(ray_pkg::CAM_ADDR_FWD_Y, fwd.y);
    write_reg(ray_pkg::CAM_ADDR_FWD_Z, fwd.z);
  endtask

  task automatic write_camera(input ray_pkg::vec3 pos, input ray_pkg::vec3 fwd);
    write_reg(ray_pkg::CAM_ADDR_POS_X, pos.x);
    write_reg(ray_pkg::CAM_ADDR_POS_Y, pos.y);
    write_reg(ray_pkg::CAM_ADDR_POS_Z, pos.z);
    write_forward(fwd);
  endtask

  task automatic pulse_start();
    @(posedge clk_in);
    #1;
    start = 1'b1;
    @(posedge clk_in);
    #1;
    start = 1'b0;
  endtask

  task automatic begin_frame();
    ray_q.delete();
    done_base = done_count;
    pulse_start();
  endtask

  task automatic wait_for_rays(input int count);
    int waited;
    waited = 0;
    while (ray_q.size() < count && waited < FRAME_CYCLE_LIMIT) begin
      @(posedge clk_in);
      #1;
      waited++;
    end
    if (ray_q.size() < count) begin
      error_count++;
      $display("only %0d of %0d rays arrived in time", ray_q.size(), count);
    end
  endtask

  task automatic wait_frame_done();
    int waited;
    waited = 0;
    while (done_count == done_base && waited < FRAME_CYCLE_LIMIT) begin
      @(posedge clk_in);
      #1;
      waited++;
    end
    if (done_count == done_base) begin
      error_count++;
      $display("frame did not finish within %0d cycles", FRAME_CYCLE_LIMIT);
    end
    // a few idle cycles so a stray second pulse would be counted
    repeat (4) @(posedge clk_in);
    #1;
    check_value("frame_done pulses", done_count - done_base, 1.0, 0.0);
    check_value("rays before frame_done", rays_at_done, NUM_PIXELS, 0.0);
  endtask

  task automatic check_frame(input ray_pkg::vec3 pos, input ray_pkg::vec3 fwd,
                             input bit check_length);
    real fx, fy, fz, dx, dy, dz;
    int n;
    int h;
    int v;
    fx = fp_to_real(fwd.x);
    fy = fp_to_real(fwd.y);
    fz = fp_to_real(fwd.z);
    check_value("ray count", ray_q.size(), NUM_PIXELS, 0.0);
    n = (ray_q.size() < NUM_PIXELS) ? ray_q.size() : NUM_PIXELS;
    for (int i = 0; i < n; i++) begin
      // raster order, hcount fastest
      h = i % ray_pkg::DISPLAY_WIDTH;
      v = i / ray_pkg::DISPLAY_WIDTH;
      check_value($sformatf("ray %0d hcount", i), ray_q[i].hcount, h, 0.0);
      check_value($sformatf("ray %0d vcount", i), ray_q[i].vcount, v, 0.0);
      check_value($sformatf("ray %0d origin.x", i), ray_q[i].origin.x, pos.x, 0.0);
      check_value($sformatf("ray %0d origin.y", i), ray_q[i].origin.y, pos.y, 0.0);
      check_value($sformatf("ray %0d origin.z", i), ray_q[i].origin.z, pos.z, 0.0);
      dx = fp_to_real(ray_q[i].direction.x);
      dy = fp_to_real(ray_q[i].direction.y);
      dz = fp_to_real(ray_q[i].direction.z);
      check_value($sformatf("ray %0d direction.x", i), dx,
                  ref_component(fx, fy, fz, h, v, 0), DIR_TOL);
      check_value($sformatf("ray %0d direction.y", i), dy,
                  ref_component(fx, fy, fz, h, v, 1), DIR_TOL);
      check_value($sformatf("ray %0d direction.z", i), dz,
                  ref_component(fx, fy, fz, h, v, 2), DIR_TOL);
      if (check_length) begin
        check_value($sformatf("ray %0d squared length", i), dx * dx + dy * dy + dz * dz,
                    1.0, LEN_TOL);
      end
    end
  endtask

  task automatic test_reset_state();
    // no frame started yet, so nothing may toggle
    for (int i = 0; i < 10; i++) begin
      check_value("ray_valid", ray_valid, 0.0, 0.0);
      check_value("frame_busy", frame_busy, 0.0, 0.0);
      check_value("frame_done", frame_done, 0.0, 0.0);
      @(posedge clk_in);
      #1;
    end
  endtask

  task automatic test_default_frame();
    begin_frame();
    wait_frame_done();
    check_frame(vec_of(0.0, 0.0, 0.0), vec_of(0.0, 0.0, 1.0), 1'b0);
  endtask

  task automatic test_camera_write();
    write_camera(cam_a_pos, cam_a_fwd);
    begin_frame();
    wait_frame_done();
    check_frame(cam_a_pos, cam_a_fwd, 1'b0);
  endtask

  task automatic test_frame_latching();
    begin_frame();
    wait_for_rays(16);
    write_camera(cam_b_pos, cam_b_fwd);
    wait_frame_done();
    check_frame(cam_a_pos, cam_a_fwd, 1'b0);
    begin_frame();
    wait_frame_done();
    check_frame(cam_b_pos, cam_b_fwd, 1'b0);
  endtask

  task automatic test_random_forward();
    // |x| and |y| below 0.5, z in [0.5, 1.0)
    rand_fwd.x = ray_pkg::fp'($random(seed) % 32768);
    rand_fwd.y = ray_pkg::fp'($random(seed) % 32768);
    rand_fwd.z = ray_pkg::fp'(32768 + ($unsigned($random(seed)) % 32768));
    write_forward(rand_fwd);
    begin_frame();
    wait_frame_done();
    check_frame(cam_b_pos, rand_fwd, 1'b1);
  endtask

  task automatic test_start_while_busy();
    begin_frame();
    wait_for_rays(5);
    check_value("frame_busy during frame", frame_busy, 1.0, 0.0);
    pulse_start();
    wait_frame_done();
    check_frame(cam_b_pos, rand_fwd, 1'b0);
    // long enough for a second frame to emit its first ray
    repeat (40) @(posedge clk_in);
    #1;
    check_value("frame_busy after frame", frame_busy, 0.0, 0.0);
    check_value("rays after frame", ray_q.size(), NUM_PIXELS, 0.0);
  endtask

  initial begin
    seed = 32'he934_1fd7;
    rst_in = 1'b1;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    start = 1'b0;
    cam_a_pos = vec_of(1.5, -2.25, 3.0);
    cam_a_fwd = vec_of(0.25, -0.125, 0.875);
    cam_b_pos = vec_of(-4.0, 0.5, -1.25);
    cam_b_fwd = vec_of(-0.375, 0.25, 0.75);
    repeat (8) @(posedge clk_in);
    #1;
    rst_in = 1'b0;

    test_reset_state();
    finish_test("reset state");
    test_default_frame();
    finish_test("default frame");
    test_camera_write();
    finish_test("camera write");
    test_frame_latching();
    finish_test("frame boundary latching");
    test_random_forward();
    finish_test("normalization");
    test_start_while_busy();
    finish_test("start while busy");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_count, failed_tests, check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: sim.f
src/ray_pkg.sv
src/camera_regs.sv
src/pixel_scanner.sv
src/fp_inv_sqrt_folded.sv
src/ray_generator_folded.sv
src/ray_caster_top.sv
test/ray_caster_asserts.sv
test/ray_caster_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module ray_caster_tb -f sim.f -Mdir obj_dir

sim_output=$(./obj_dir/Vray_caster_tb || true)
echo "$sim_output"

if echo "$sim_output" | grep -qx "=== PASS ==="; then
  exit 0
fi
exit 1
